// ==== include/mem_port_settings.svh ====
// bus widths, access-mode codes, read sizes, response codes, SRAM depth, write ID
`ifndef MEM_PORT_SETTINGS_SVH
`define MEM_PORT_SETTINGS_SVH

// bus widths
`define ADDR_W      32
`define DATA_W      32
`define BUS_W       64
`define STRB_W      8
`define ID_W        4

// ID carried by every data-port write
`define WRITE_ID    4'd1

// 64-bit words, 4 KiB window from address 0
`define SRAM_WORDS  512

// access modes, same encoding as the load/store funct3 field
`define MODE_BYTE   3'd0
`define MODE_HALF   3'd1
`define MODE_WORD   3'd2
`define MODE_BYTE_U 3'd4
`define MODE_HALF_U 3'd5

// log2 of the byte count of a read
`define RSIZE_BYTE  3'd0
`define RSIZE_HALF  3'd1
`define RSIZE_WORD  3'd2

// write response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

// ==== logic/mem_port_pkg.sv ====
// shared vector typedefs and FSM state enums of the memory subsystem
`include "mem_port_settings.svh"

package mem_port_pkg;

    // ==================================================
    // vectors with a meaning
    // ==================================================
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`BUS_W-1:0]  beat_t;
    typedef logic [`STRB_W-1:0] strb_t;
    typedef logic [2:0]         mode_t;
    typedef logic [2:0]         rsize_t;
    typedef logic [1:0]         resp_t;
    typedef logic [`ID_W-1:0]   id_t;

    // ==================================================
    // state machines
    // ==================================================
    typedef enum logic {
        rd_st_idle,
        rd_st_busy
    } rd_state_e;

    // address phase, then data, then response
    typedef enum logic [1:0] {
        wr_st_idle,
        wr_st_data,
        wr_st_resp
    } wr_state_e;

endpackage

// ==== logic/data_mem_port.sv ====
// CPU data-side memory port: read and write FSMs, lane steering, extension, error flag
`timescale 1ns/100ps
`include "mem_port_settings.svh"

module data_mem_port (
    input  logic                 clk,
    input  logic                 rst,
    // cpu read side
    input  logic                 rd_strobe,
    input  mem_port_pkg::addr_t  rd_addr,
    output mem_port_pkg::word_t  rd_data,
    output logic                 rd_done,
    // cpu write side
    input  logic                 wr_strobe,
    input  mem_port_pkg::addr_t  wr_addr,
    input  mem_port_pkg::word_t  wr_data,
    output logic                 wr_done,
    input  mem_port_pkg::mode_t  mode,
    // read request channel towards the arbiter
    output mem_port_pkg::addr_t  dreq_addr,
    output mem_port_pkg::rsize_t dreq_size,
    output logic                 dreq_valid,
    input  logic                 dreq_ready,
    input  mem_port_pkg::word_t  drsp_data,
    input  logic                 drsp_valid,
    output logic                 drsp_ready,
    // write channel
    output logic                 awvalid,
    output mem_port_pkg::addr_t  awaddr,
    output mem_port_pkg::id_t    awid,
    input  logic                 awready,
    output logic                 wvalid,
    output mem_port_pkg::beat_t  wdata,
    output mem_port_pkg::strb_t  wstrb,
    output logic                 wlast,
    input  logic                 wready,
    input  logic                 bvalid,
    input  mem_port_pkg::resp_t  bresp,
    input  mem_port_pkg::id_t    bid,
    output logic                 bready,
    output logic                 mem_error
);

    mem_port_pkg::rd_state_e rd_state;
    mem_port_pkg::wr_state_e wr_state;
    logic                    rd_pend;
    logic                    wr_pend;
    mem_port_pkg::addr_t     rd_addr_q;
    mem_port_pkg::mode_t     rd_mode_q;
    mem_port_pkg::addr_t     wr_addr_q;
    mem_port_pkg::word_t     wr_data_q;
    mem_port_pkg::mode_t     wr_mode_q;
    mem_port_pkg::strb_t     strb_base;
    mem_port_pkg::word_t     wr_lane_word;
    mem_port_pkg::word_t     rd_ext;
    logic                    ar_fire;
    logic                    r_fire;
    logic                    aw_fire;
    logic                    w_fire;
    logic                    b_fire;

    // request payload, held from the strobe on
    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            rd_addr_q <= rd_addr;
            rd_mode_q <= mode;
        end
        if (wr_strobe) begin
            wr_addr_q <= wr_addr;
            wr_data_q <= wr_data;
            wr_mode_q <= mode;
        end
    end

    // ==================================================
    // read side
    // ==================================================
    assign ar_fire    = dreq_valid & dreq_ready;
    assign r_fire     = drsp_valid & drsp_ready;
    assign dreq_valid = rd_pend;
    assign dreq_addr  = rd_addr_q;
    assign drsp_ready = (rd_state == mem_port_pkg::rd_st_busy);
    // low from the strobe cycle until the response is captured
    assign rd_done    = ~rd_strobe & ~rd_pend & (rd_state == mem_port_pkg::rd_st_idle);

    always_comb begin
        case (rd_mode_q)
            `MODE_BYTE, `MODE_BYTE_U: dreq_size = `RSIZE_BYTE;
            `MODE_HALF, `MODE_HALF_U: dreq_size = `RSIZE_HALF;
            default:                  dreq_size = `RSIZE_WORD;
        endcase
    end

    // response arrives right-aligned
    always_comb begin
        case (rd_mode_q)
            `MODE_BYTE:   rd_ext = {{24{drsp_data[7]}}, drsp_data[7:0]};
            `MODE_HALF:   rd_ext = {{16{drsp_data[15]}}, drsp_data[15:0]};
            `MODE_BYTE_U: rd_ext = {24'd0, drsp_data[7:0]};
            `MODE_HALF_U: rd_ext = {16'd0, drsp_data[15:0]};
            default:      rd_ext = drsp_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend  <= 1'b0;
            rd_state <= mem_port_pkg::rd_st_idle;
        end else begin
            if (rd_strobe) begin
                rd_pend <= 1'b1;
            end else if (ar_fire) begin
                rd_pend <= 1'b0;
            end
            case (rd_state)
                mem_port_pkg::rd_st_idle: begin
                    if (ar_fire) begin
                        rd_state <= mem_port_pkg::rd_st_busy;
                    end
                end
                default: begin
                    if (r_fire) begin
                        rd_state <= mem_port_pkg::rd_st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            rd_data <= rd_ext;
        end
    end

    // ==================================================
    // write side
    // ==================================================
    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;
    assign b_fire  = bvalid & bready;
    assign awvalid = wr_pend;
    assign awaddr  = wr_addr_q;
    assign awid    = `WRITE_ID;
    assign wvalid  = (wr_state == mem_port_pkg::wr_st_data);
    // single-beat writes only
    assign wlast   = wvalid;
    assign bready  = (wr_state == mem_port_pkg::wr_st_resp);
    assign wr_done = ~wr_strobe & ~wr_pend & (wr_state == mem_port_pkg::wr_st_idle);

    always_comb begin
        case (wr_mode_q)
            `MODE_BYTE, `MODE_BYTE_U: strb_base = 8'h01;
            `MODE_HALF, `MODE_HALF_U: strb_base = 8'h03;
            default:                  strb_base = 8'h0f;
        endcase
    end

    // data moved to its lane inside the word, word copied to both beat halves
    assign wstrb        = strb_base << wr_addr_q[2:0];
    assign wr_lane_word = wr_data_q << {wr_addr_q[1:0], 3'b000};
    assign wdata        = {(`BUS_W / `DATA_W){wr_lane_word}};

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pend  <= 1'b0;
            wr_state <= mem_port_pkg::wr_st_idle;
        end else begin
            if (wr_strobe) begin
                wr_pend <= 1'b1;
            end else if (aw_fire) begin
                wr_pend <= 1'b0;
            end
            case (wr_state)
                mem_port_pkg::wr_st_idle: begin
                    if (aw_fire) begin
                        wr_state <= mem_port_pkg::wr_st_data;
                    end
                end
                mem_port_pkg::wr_st_data: begin
                    if (w_fire) begin
                        wr_state <= mem_port_pkg::wr_st_resp;
                    end
                end
                default: begin
                    if (b_fire) begin
                        wr_state <= mem_port_pkg::wr_st_idle;
                    end
                end
            endcase
        end
    end

    // sticky until the next response
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_error <= 1'b0;
        end else if (b_fire) begin
            mem_error <= (bresp != `RESP_OKAY) || (bid != `WRITE_ID);
        end
    end

endmodule

// ==== logic/read_arbiter.sv ====
// fixed-priority arbiter sharing one read channel between data port and fetch
`timescale 1ns/100ps
`include "mem_port_settings.svh"

module read_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    // data port
    input  mem_port_pkg::addr_t  dreq_addr,
    input  mem_port_pkg::rsize_t dreq_size,
    input  logic                 dreq_valid,
    output logic                 dreq_ready,
    output mem_port_pkg::word_t  drsp_data,
    output logic                 drsp_valid,
    input  logic                 drsp_ready,
    // fetch side
    input  logic                 fetch_strobe,
    input  mem_port_pkg::addr_t  fetch_addr,
    output mem_port_pkg::word_t  fetch_data,
    output logic                 fetch_valid,
    // sram read channel
    output mem_port_pkg::addr_t  araddr,
    output mem_port_pkg::rsize_t arsize,
    output logic                 arvalid,
    input  logic                 arready,
    input  mem_port_pkg::word_t  rdata,
    input  logic                 rvalid,
    output logic                 rready
);

    logic                fetch_pend;
    mem_port_pkg::addr_t fetch_addr_q;
    logic                busy;
    logic                owner_fetch;
    logic                sel_fetch;
    logic                ar_fire;
    logic                r_fire;

    // data port wins when idle, owner is frozen while busy
    assign sel_fetch  = busy ? owner_fetch : (~dreq_valid & fetch_pend);
    assign arvalid    = ~busy & (dreq_valid | fetch_pend);
    assign araddr     = sel_fetch ? fetch_addr_q : dreq_addr;
    assign arsize     = sel_fetch ? `RSIZE_WORD : dreq_size;
    assign dreq_ready = ~busy & arready;
    assign ar_fire    = arvalid & arready;

    // response routed back to the owner
    assign rready     = busy & (owner_fetch | drsp_ready);
    assign drsp_valid = busy & ~owner_fetch & rvalid;
    assign drsp_data  = rdata;
    assign r_fire     = rvalid & rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pend  <= 1'b0;
            busy        <= 1'b0;
            owner_fetch <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            if (fetch_strobe) begin
                fetch_pend <= 1'b1;
            end else if (ar_fire && sel_fetch) begin
                fetch_pend <= 1'b0;
            end
            if (ar_fire) begin
                busy        <= 1'b1;
                owner_fetch <= sel_fetch;
            end else if (r_fire) begin
                busy <= 1'b0;
            end
            fetch_valid <= r_fire & owner_fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_strobe) begin
            fetch_addr_q <= fetch_addr;
        end
        if (r_fire && owner_fetch) begin
            fetch_data <= rdata;
        end
    end

endmodule

// ==== logic/axi_sram.sv ====
// on-chip SRAM slave with a valid/ready read channel and a three-phase write channel
`timescale 1ns/100ps
`include "mem_port_settings.svh"

module axi_sram (
    input  logic                 clk,
    input  logic                 rst,
    // read channel
    input  mem_port_pkg::addr_t  araddr,
    input  mem_port_pkg::rsize_t arsize,
    input  logic                 arvalid,
    output logic                 arready,
    output mem_port_pkg::word_t  rdata,
    output logic                 rvalid,
    input  logic                 rready,
    // write address
    input  logic                 awvalid,
    output logic                 awready,
    input  mem_port_pkg::addr_t  awaddr,
    input  mem_port_pkg::id_t    awid,
    // write data
    input  logic                 wvalid,
    output logic                 wready,
    input  mem_port_pkg::beat_t  wdata,
    input  mem_port_pkg::strb_t  wstrb,
    input  logic                 wlast,
    // write response
    output logic                 bvalid,
    input  logic                 bready,
    output mem_port_pkg::resp_t  bresp,
    output mem_port_pkg::id_t    bid
);

    localparam int IDX_W = $clog2(`SRAM_WORDS);

    mem_port_pkg::beat_t     mem [`SRAM_WORDS];
    mem_port_pkg::beat_t     rd_beat;
    mem_port_pkg::word_t     rd_word;
    mem_port_pkg::wr_state_e wr_state;
    mem_port_pkg::addr_t     aw_addr_q;
    logic                    aw_in_range;
    logic                    ar_fire;
    logic                    aw_fire;
    logic                    w_fire;

    // ==================================================
    // read channel
    // ==================================================
    assign arready = ~rvalid;
    assign ar_fire = arvalid & arready;
    assign rd_beat = mem[araddr[IDX_W+2:3]] >> {araddr[2:0], 3'b000};

    always_comb begin
        case (arsize)
            `RSIZE_BYTE: rd_word = {24'd0, rd_beat[7:0]};
            `RSIZE_HALF: rd_word = {16'd0, rd_beat[15:0]};
            default:     rd_word = rd_beat[31:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= rd_word;
        end
    end

    // ==================================================
    // write channel
    // ==================================================
    assign awready     = (wr_state == mem_port_pkg::wr_st_idle);
    assign wready      = (wr_state == mem_port_pkg::wr_st_data);
    assign bvalid      = (wr_state == mem_port_pkg::wr_st_resp);
    assign aw_fire     = awvalid & awready;
    assign w_fire      = wvalid & wready;
    assign aw_in_range = (aw_addr_q >> 3) < mem_port_pkg::addr_t'(`SRAM_WORDS);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= mem_port_pkg::wr_st_idle;
        end else begin
            case (wr_state)
                mem_port_pkg::wr_st_idle: begin
                    if (aw_fire) begin
                        wr_state <= mem_port_pkg::wr_st_data;
                    end
                end
                mem_port_pkg::wr_st_data: begin
                    if (w_fire && wlast) begin
                        wr_state <= mem_port_pkg::wr_st_resp;
                    end
                end
                default: begin
                    if (bready) begin
                        wr_state <= mem_port_pkg::wr_st_idle;
                    end
                end
            endcase
        end
    end

    // address and id held for the data and response phases
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_addr_q <= awaddr;
            bid       <= awid;
        end
        if (w_fire) begin
            bresp <= aw_in_range ? `RESP_OKAY : `RESP_SLVERR;
        end
    end

    // byte merge, nothing stored outside the window
    always_ff @(posedge clk) begin
        if (w_fire && aw_in_range) begin
            for (int i = 0; i < `STRB_W; i++) begin
                if (wstrb[i]) begin
                    mem[aw_addr_q[IDX_W+2:3]][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/mem_subsystem_top.sv ====
// memory subsystem top: data port, read arbiter and SRAM slave
`timescale 1ns/100ps

module mem_subsystem_top (
    input  logic                clk,
    input  logic                rst,
    // cpu data side
    input  logic                rd_strobe,
    input  mem_port_pkg::addr_t rd_addr,
    output mem_port_pkg::word_t rd_data,
    input  logic                wr_strobe,
    input  mem_port_pkg::addr_t wr_addr,
    input  mem_port_pkg::word_t wr_data,
    input  mem_port_pkg::mode_t mode,
    output logic                rd_done,
    output logic                wr_done,
    output logic                mem_error,
    // fetch side
    input  logic                fetch_strobe,
    input  mem_port_pkg::addr_t fetch_addr,
    output mem_port_pkg::word_t fetch_data,
    output logic                fetch_valid
);

    // ==================================================
    // data port to arbiter
    // ==================================================
    mem_port_pkg::addr_t  dreq_addr;
    mem_port_pkg::rsize_t dreq_size;
    logic                 dreq_valid;
    logic                 dreq_ready;
    mem_port_pkg::word_t  drsp_data;
    logic                 drsp_valid;
    logic                 drsp_ready;

    // arbiter to sram
    mem_port_pkg::addr_t  araddr;
    mem_port_pkg::rsize_t arsize;
    logic                 arvalid;
    logic                 arready;
    mem_port_pkg::word_t  rdata;
    logic                 rvalid;
    logic                 rready;

    // write channel
    logic                 awvalid;
    logic                 awready;
    mem_port_pkg::addr_t  awaddr;
    mem_port_pkg::id_t    awid;
    logic                 wvalid;
    logic                 wready;
    mem_port_pkg::beat_t  wdata;
    mem_port_pkg::strb_t  wstrb;
    logic                 wlast;
    logic                 bvalid;
    logic                 bready;
    mem_port_pkg::resp_t  bresp;
    mem_port_pkg::id_t    bid;

    data_mem_port u_data_mem_port (
        .clk        (clk),
        .rst        (rst),
        .rd_strobe  (rd_strobe),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_done    (rd_done),
        .wr_strobe  (wr_strobe),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_done    (wr_done),
        .mode       (mode),
        .dreq_addr  (dreq_addr),
        .dreq_size  (dreq_size),
        .dreq_valid (dreq_valid),
        .dreq_ready (dreq_ready),
        .drsp_data  (drsp_data),
        .drsp_valid (drsp_valid),
        .drsp_ready (drsp_ready),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awid       (awid),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wlast      (wlast),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bid        (bid),
        .bready     (bready),
        .mem_error  (mem_error)
    );

    read_arbiter u_read_arbiter (
        .clk          (clk),
        .rst          (rst),
        .dreq_addr    (dreq_addr),
        .dreq_size    (dreq_size),
        .dreq_valid   (dreq_valid),
        .dreq_ready   (dreq_ready),
        .drsp_data    (drsp_data),
        .drsp_valid   (drsp_valid),
        .drsp_ready   (drsp_ready),
        .fetch_strobe (fetch_strobe),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .fetch_valid  (fetch_valid),
        .araddr       (araddr),
        .arsize       (arsize),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .rready       (rready)
    );

    axi_sram u_axi_sram (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arsize  (arsize),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awid    (awid),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .bid     (bid)
    );

endmodule

// ==== verif/mem_subsystem_tb.sv ====
// testbench for the memory subsystem: clock, reset, LFSR, byte model, directed and random checks
`timescale 1ns/100ps
`include "mem_port_settings.svh"

module mem_subsystem_tb;

    localparam int WAIT_LIMIT = 64;
    localparam mem_port_pkg::addr_t WIN_BYTES = mem_port_pkg::addr_t'(`SRAM_WORDS * 8);

    // byte index inside the SRAM window
    typedef logic [$clog2(`SRAM_WORDS * 8)-1:0] idx_t;

    logic                clk;
    logic                rst;
    logic                rd_strobe;
    mem_port_pkg::addr_t rd_addr;
    mem_port_pkg::word_t rd_data;
    logic                wr_strobe;
    mem_port_pkg::addr_t wr_addr;
    mem_port_pkg::word_t wr_data;
    mem_port_pkg::mode_t mode;
    logic                rd_done;
    logic                wr_done;
    logic                mem_error;
    logic                fetch_strobe;
    mem_port_pkg::addr_t fetch_addr;
    mem_port_pkg::word_t fetch_data;
    logic                fetch_valid;

    logic [7:0]          ref_mem [`SRAM_WORDS * 8];
    logic [31:0]         lfsr;

    mem_subsystem_top dut (
        .clk          (clk),
        .rst          (rst),
        .rd_strobe    (rd_strobe),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .wr_strobe    (wr_strobe),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .mode         (mode),
        .rd_done      (rd_done),
        .wr_done      (wr_done),
        .mem_error    (mem_error),
        .fetch_strobe (fetch_strobe),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .fetch_valid  (fetch_valid)
    );

    always #2 clk = ~clk;

    // ==================================================
    // failure reporting and checks
    // ==================================================
    task automatic fail_now(input string line);
        $display("%s", line);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp)
        else begin
            fail_now($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_word(input string what, input mem_port_pkg::word_t got,
                              input mem_port_pkg::word_t exp);
        assert (got === exp)
        else begin
            fail_now($sformatf("ERR %0t: %s got %08h, expected %08h", $time, what, got, exp));
        end
    endtask

    // error flag only moves on a write response
    error_follows_write: assert property (@(posedge clk) disable iff (rst)
        $changed(mem_error) |-> !$past(wr_done))
        else fail_now($sformatf("ERR %0t: mem_error moved with no write in flight", $time));

    // ==================================================
    // random bits and reference model
    // ==================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic int mode_bytes(input mem_port_pkg::mode_t m);
        case (m)
            `MODE_BYTE, `MODE_BYTE_U: return 1;
            `MODE_HALF, `MODE_HALF_U: return 2;
            default:                  return 4;
        endcase
    endfunction

    function automatic mem_port_pkg::addr_t align(input mem_port_pkg::addr_t a,
                                                  input mem_port_pkg::mode_t m);
        return a & ~mem_port_pkg::addr_t'(mode_bytes(m) - 1);
    endfunction

    // initial contents, every bit of the address shows up in the word
    function automatic mem_port_pkg::word_t fill_value(input mem_port_pkg::addr_t a);
        return {~a[15:0], a[15:0]} ^ 32'h3c96_0f12;
    endfunction

    // little-endian bytes, extension by mode
    function automatic mem_port_pkg::word_t expect_read(input mem_port_pkg::addr_t a,
                                                        input mem_port_pkg::mode_t m);
        idx_t       i0;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        i0 = idx_t'(a);
        b0 = ref_mem[i0];
        b1 = ref_mem[i0 + idx_t'(1)];
        b2 = ref_mem[i0 + idx_t'(2)];
        b3 = ref_mem[i0 + idx_t'(3)];
        case (m)
            `MODE_BYTE:   return {{24{b0[7]}}, b0};
            `MODE_HALF:   return {{16{b1[7]}}, b1, b0};
            `MODE_BYTE_U: return {24'd0, b0};
            `MODE_HALF_U: return {16'd0, b1, b0};
            default:      return {b3, b2, b1, b0};
        endcase
    endfunction

    function automatic void model_write(input mem_port_pkg::addr_t a,
                                        input mem_port_pkg::mode_t m,
                                        input mem_port_pkg::word_t d);
        idx_t k;
        k = idx_t'(a);
        for (int i = 0; i < mode_bytes(m); i++) begin
            ref_mem[k] = d[i*8 +: 8];
            k          = k + idx_t'(1);
        end
    endfunction

    // ==================================================
    // stimulus and waits
    // ==================================================
    task automatic issue(input logic rd, input logic wr, input logic fe,
                         input mem_port_pkg::addr_t a, input mem_port_pkg::addr_t fa,
                         input mem_port_pkg::mode_t m, input mem_port_pkg::word_t d);
        rd_strobe    <= rd;
        wr_strobe    <= wr;
        fetch_strobe <= fe;
        rd_addr      <= a;
        wr_addr      <= a;
        wr_data      <= d;
        fetch_addr   <= fa;
        mode         <= m;
        @(posedge clk);
        // done flags drop while the strobe is high
        if (rd) begin
            check_bit("rd_done in strobe cycle", rd_done, 1'b0);
        end
        if (wr) begin
            check_bit("wr_done in strobe cycle", wr_done, 1'b0);
        end
        rd_strobe    <= 1'b0;
        wr_strobe    <= 1'b0;
        fetch_strobe <= 1'b0;
    endtask

    task automatic wait_read(input mem_port_pkg::addr_t a, input mem_port_pkg::mode_t m);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!rd_done) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now("timeout waiting for rd_done to return after a read");
            end
            @(posedge clk);
        end
        check_word($sformatf("read %08h mode %0d", a, m), rd_data, expect_read(a, m));
    endtask

    task automatic wait_write(input mem_port_pkg::addr_t a, input mem_port_pkg::mode_t m,
                              input mem_port_pkg::word_t d);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!wr_done) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now("timeout waiting for wr_done to return after a write");
            end
            @(posedge clk);
        end
        check_bit($sformatf("mem_error after write to %08h", a), mem_error, a >= WIN_BYTES);
        if (a < WIN_BYTES) begin
            model_write(a, m, d);
        end
    endtask

    task automatic wait_fetch(input mem_port_pkg::addr_t fa);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!fetch_valid) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_now("timeout waiting for fetch_valid after a fetch");
            end
            @(posedge clk);
        end
        check_word($sformatf("fetch %08h", fa), fetch_data, expect_read(fa, `MODE_WORD));
    endtask

    task automatic read_check(input mem_port_pkg::addr_t a, input mem_port_pkg::mode_t m);
        issue(1'b1, 1'b0, 1'b0, a, '0, m, '0);
        wait_read(a, m);
    endtask

    task automatic write_op(input mem_port_pkg::addr_t a, input mem_port_pkg::mode_t m,
                            input mem_port_pkg::word_t d);
        issue(1'b0, 1'b1, 1'b0, a, '0, m, d);
        wait_write(a, m, d);
    endtask

    task automatic fetch_check(input mem_port_pkg::addr_t fa);
        issue(1'b0, 1'b0, 1'b1, '0, fa, `MODE_WORD, '0);
        wait_fetch(fa);
    endtask

    // both requests in the same cycle, data side has priority
    task automatic read_and_fetch(input mem_port_pkg::addr_t a, input mem_port_pkg::mode_t m,
                                  input mem_port_pkg::addr_t fa);
        issue(1'b1, 1'b0, 1'b1, a, fa, m, '0);
        fork
            wait_read(a, m);
            wait_fetch(fa);
        join
    endtask

    task automatic fill_window();
        mem_port_pkg::addr_t a;
        for (int w = 0; w < `SRAM_WORDS * 2; w++) begin
            a = mem_port_pkg::addr_t'(w * 4);
            write_op(a, `MODE_WORD, fill_value(a));
        end
    endtask

    task automatic random_ops(input int count);
        int                  op;
        int                  pick;
        mem_port_pkg::mode_t m;
        mem_port_pkg::addr_t a;
        mem_port_pkg::addr_t fa;
        mem_port_pkg::word_t d;
        for (int n = 0; n < count; n++) begin
            op   = int'(rand_bits(2));
            pick = int'(rand_bits(3)) % 5;
            case (pick)
                0:       m = `MODE_BYTE;
                1:       m = `MODE_HALF;
                2:       m = `MODE_WORD;
                3:       m = `MODE_BYTE_U;
                default: m = `MODE_HALF_U;
            endcase
            a  = align(rand_bits(12), m);
            fa = align(rand_bits(12), `MODE_WORD);
            d  = rand_bits(32);
            case (op)
                0: read_check(a, m);
                1: begin
                    // about one write in four lands outside the window
                    if (rand_bits(2) == 0) begin
                        a = a + WIN_BYTES;
                    end
                    write_op(a, m, d);
                end
                2:       fetch_check(fa);
                default: read_and_fetch(a, m, fa);
            endcase
        end
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        rd_strobe    = 1'b0;
        rd_addr      = '0;
        wr_strobe    = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        mode         = `MODE_WORD;
        fetch_strobe = 1'b0;
        fetch_addr   = '0;
        lfsr         = 32'd68741;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_bit("rd_done after reset", rd_done, 1'b1);
        check_bit("wr_done after reset", wr_done, 1'b1);
        check_bit("mem_error after reset", mem_error, 1'b0);
        check_bit("fetch_valid after reset", fetch_valid, 1'b0);

        fill_window();

        // word write and read back
        write_op(32'h0000_0100, `MODE_WORD, 32'hdead_beef);
        read_check(32'h0000_0100, `MODE_WORD);

        // every byte lane, upper data bits must not leak
        for (int i = 0; i < 8; i++) begin
            write_op(mem_port_pkg::addr_t'(32'h300 + i), `MODE_BYTE,
                     (i % 2 == 0) ? 32'h1234_56a5 : 32'hcdef_015a);
            read_check(mem_port_pkg::addr_t'(32'h300 + i), `MODE_BYTE);
            read_check(mem_port_pkg::addr_t'(32'h300 + i), `MODE_BYTE_U);
            read_check(align(mem_port_pkg::addr_t'(32'h300 + i), `MODE_WORD), `MODE_WORD);
        end
        for (int i = 0; i < 4; i++) begin
            write_op(mem_port_pkg::addr_t'(32'h400 + 2 * i), `MODE_HALF,
                     (i % 2 == 0) ? 32'hffff_7e02 : 32'h0000_8f01);
            read_check(mem_port_pkg::addr_t'(32'h400 + 2 * i), `MODE_HALF);
            read_check(mem_port_pkg::addr_t'(32'h400 + 2 * i), `MODE_HALF_U);
            read_check(align(mem_port_pkg::addr_t'(32'h400 + 2 * i), `MODE_WORD), `MODE_WORD);
        end

        // out of window: error set, aliased location untouched, next write clears
        write_op(WIN_BYTES + 32'h100, `MODE_WORD, 32'h0bad_0bad);
        read_check(32'h0000_0100, `MODE_WORD);
        check_bit("mem_error held across a read", mem_error, 1'b1);
        write_op(32'h0000_0104, `MODE_WORD, 32'h600d_f00d);

        read_and_fetch(32'h0000_0302, `MODE_HALF, 32'h0000_0100);
        read_and_fetch(32'h0000_0403, `MODE_BYTE_U, 32'h0000_0404);

        random_ops(200);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
logic/mem_port_pkg.sv
logic/data_mem_port.sv
logic/read_arbiter.sv
logic/axi_sram.sv
logic/mem_subsystem_top.sv
verif/mem_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory subsystem testbench

TOP = mem_subsystem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir

# a failing run ends in $fatal, which gives a nonzero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
